/* src/cpu_pkg.sv */
package cpu_pkg;

    // ------------------------------------------------------------------------
    // Flag byte layout
    // ------------------------------------------------------------------------
    localparam int flag_c = 0;                  // Carry or borrow
    localparam int flag_p = 2;                  // Even parity
    localparam int flag_h = 4;                  // Half carry
    localparam int flag_z = 6;                  // Zero
    localparam int flag_s = 7;                  // Sign

    localparam logic [7:0] flags_reset = 8'b0000_0010;

    // ------------------------------------------------------------------------
    // ALU operation, opcode bits 5..3
    // ------------------------------------------------------------------------
    localparam logic [2:0] alu_add = 3'd0;
    localparam logic [2:0] alu_adc = 3'd1;
    localparam logic [2:0] alu_sub = 3'd2;
    localparam logic [2:0] alu_sbb = 3'd3;
    localparam logic [2:0] alu_and = 3'd4;
    localparam logic [2:0] alu_xor = 3'd5;
    localparam logic [2:0] alu_or  = 3'd6;
    localparam logic [2:0] alu_cmp = 3'd7;

    localparam logic [2:0] reg_a_idx = 3'd7;    // Index 6 is M, not a register

    typedef struct packed {
        logic       en;
        logic [2:0] idx;
        logic [7:0] data;
    } reg_wr_t;

    typedef struct packed {
        logic       alu_op;                     // Two-operand ALU operation
        logic       inc_dec;                    // INR or DCR
        logic       dec;                        // Decrement when set
        logic [2:0] op;
        logic [7:0] operand;
    } alu_req_t;

    typedef struct packed {
        logic       we;
        logic [7:0] addr;
        logic [7:0] data;
    } port_wr_t;

endpackage

/* src/alu_unit.sv */
`timescale 1ns/10ps

module alu_unit
    import cpu_pkg::*;
(
    input  logic       clock,
    input  logic       reset_n,
    input  logic       ce,
    input  logic [7:0] acc,
    input  alu_req_t   alu_req,
    output logic [7:0] alu_result,
    output logic [7:0] flags
);

    logic [8:0] sum;                            // Bit 8 is carry or borrow
    logic [7:0] inc_res;
    logic       carry;
    logic       logic_op;
    logic       half;
    logic [7:0] alu_flags;
    logic [7:0] idc_flags;

    assign carry = flags[flag_c];

    // ------------------------------------------------------------------------
    // Two-operand operations
    // ------------------------------------------------------------------------
    always_comb begin
        case (alu_req.op)
            alu_add: sum = {1'b0, acc} + {1'b0, alu_req.operand};
            alu_adc: sum = {1'b0, acc} + {1'b0, alu_req.operand} + {8'h00, carry};
            alu_sub: sum = {1'b0, acc} - {1'b0, alu_req.operand};
            alu_sbb: sum = {1'b0, acc} - {1'b0, alu_req.operand} - {8'h00, carry};
            alu_and: sum = {1'b0, acc & alu_req.operand};
            alu_xor: sum = {1'b0, acc ^ alu_req.operand};
            alu_or:  sum = {1'b0, acc | alu_req.operand};
            alu_cmp: sum = {1'b0, acc} - {1'b0, alu_req.operand};   // Flags only
        endcase
    end

    assign logic_op = (alu_req.op == alu_and) || (alu_req.op == alu_xor) ||
                      (alu_req.op == alu_or);

    assign half = logic_op ?
        ((alu_req.op == alu_and) && (acc[4] || alu_req.operand[4])) :
        (acc[4] ^ alu_req.operand[4] ^ sum[4]);

    assign inc_res = alu_req.dec ? alu_req.operand - 8'd1 : alu_req.operand + 8'd1;

    assign alu_result = alu_req.inc_dec ? inc_res : sum[7:0];

    always_comb begin
        alu_flags         = flags_reset;        // Fixed bits, bit 1 set
        alu_flags[flag_s] = sum[7];
        alu_flags[flag_z] = (sum[7:0] == 8'h00);
        alu_flags[flag_p] = ~^sum[7:0];
        alu_flags[flag_h] = half;
        alu_flags[flag_c] = sum[8] && !logic_op;

        idc_flags         = flags;              // H and C kept
        idc_flags[flag_s] = inc_res[7];
        idc_flags[flag_z] = (inc_res == 8'h00);
        idc_flags[flag_p] = ~^inc_res;
    end

    // ------------------------------------------------------------------------
    // Flag register
    // ------------------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            flags <= flags_reset;
        end else if (ce && alu_req.alu_op) begin
            flags <= alu_flags;
        end else if (ce && alu_req.inc_dec) begin
            flags <= idc_flags;
        end
    end

    a_one_strobe : assert property (@(posedge clock) disable iff (!reset_n)
        !(alu_req.alu_op && alu_req.inc_dec))
        else $error("ALU and inc/dec strobes high together");

endmodule

/* src/reg_file.sv */
`timescale 1ns/10ps

module reg_file
    import cpu_pkg::*;
(
    input  logic       clock,
    input  logic       reset_n,
    input  reg_wr_t    reg_wr,
    input  logic [2:0] rd_sel,
    output logic [7:0] rd_val,
    output logic [7:0] acc
);

    // B C D E H L at 0..5, A at 7
    logic [7:0] regs [0:7];

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= 8'h00;
            end
        end else if (reg_wr.en) begin
            regs[reg_wr.idx] <= reg_wr.data;     // Strobe already carries ce
        end
    end

    assign rd_val = regs[rd_sel];
    assign acc    = regs[reg_a_idx];

    a_no_mem_write : assert property (@(posedge clock) disable iff (!reset_n)
        reg_wr.en |-> (reg_wr.idx != 3'd6))
        else $error("register write to index 6");

endmodule

/* src/seq_ctrl.sv */
`timescale 1ns/10ps

module seq_ctrl
    import cpu_pkg::*;
(
    input  logic        clock,
    input  logic        reset_n,
    input  logic        ce,
    input  logic [ 7:0] rd_data,
    input  logic [ 7:0] rd_val,
    input  logic [ 7:0] acc,
    input  logic [ 7:0] alu_result,
    input  logic [ 7:0] flags,
    output logic [15:0] address,
    output logic        m0,
    output logic [ 2:0] rd_sel,
    output reg_wr_t     reg_wr,
    output alu_req_t    alu_req,
    output port_wr_t    port_wr
);

    logic [15:0] pc;
    logic [15:0] pc_next;
    logic [ 7:0] data_ptr;                      // Port number or jump low byte
    logic        addr_sel;                      // Address from data_ptr
    logic        sel_next;
    logic        ptr_load;
    logic [ 1:0] step;
    logic [ 1:0] step_next;
    logic        done;                          // Last cycle of the instruction
    logic [ 7:0] opcode;
    logic [ 7:0] opc;
    logic        we_last;
    logic        cond_flag;
    logic        jump_taken;
    logic        is_mvi;
    logic        is_mov;
    logic        is_inr_dcr;
    logic        is_alu_r;
    logic        is_alu_i;
    logic        is_jmp;
    logic        is_jcc;
    logic        is_out;
    logic        is_halt;

    assign m0      = (step == 2'd0);
    assign opc     = m0 ? rd_data : opcode;     // Decode the bus during fetch
    assign address = addr_sel ? {8'h00, data_ptr} : pc;

    // ------------------------------------------------------------------------
    // Opcode decode
    // ------------------------------------------------------------------------
    assign is_halt    = (opc == 8'h76);
    assign is_mvi     = (opc[7:6] == 2'b00) && (opc[2:0] == 3'b110) && (opc[5:3] != 3'b110);
    assign is_inr_dcr = (opc[7:6] == 2'b00) && (opc[2:1] == 2'b10) && (opc[5:3] != 3'b110);
    assign is_mov     = (opc[7:6] == 2'b01) && (opc[5:3] != 3'b110) && (opc[2:0] != 3'b110);
    assign is_alu_r   = (opc[7:6] == 2'b10) && (opc[2:0] != 3'b110);
    assign is_alu_i   = (opc[7:6] == 2'b11) && (opc[2:0] == 3'b110);
    assign is_jmp     = (opc == 8'hC3);
    assign is_jcc     = (opc[7:6] == 2'b11) && (opc[2:0] == 3'b010);
    assign is_out     = (opc == 8'hD3);

    // NZ Z NC C PO PE P M
    always_comb begin
        case (opc[5:4])
            2'b00:   cond_flag = flags[flag_z];
            2'b01:   cond_flag = flags[flag_c];
            2'b10:   cond_flag = flags[flag_p];
            default: cond_flag = flags[flag_s];
        endcase
    end

    assign jump_taken = (cond_flag == opc[3]);

    // ------------------------------------------------------------------------
    // Step sequencing
    // ------------------------------------------------------------------------
    always_comb begin
        done      = 1'b0;
        pc_next   = pc;
        sel_next  = addr_sel;
        ptr_load  = 1'b0;
        rd_sel    = is_inr_dcr ? opc[5:3] : opc[2:0];
        reg_wr    = '0;
        alu_req   = '0;
        port_wr   = '0;

        reg_wr.idx      = opc[5:3];
        reg_wr.data     = alu_result;
        alu_req.op      = opc[5:3];
        alu_req.dec     = opc[0];
        alu_req.operand = rd_val;
        port_wr.addr    = data_ptr;
        port_wr.data    = acc;

        case (step)
            2'd0: begin
                pc_next = pc + 16'd1;
                if (is_halt) begin
                    pc_next = pc;               // Refetch forever
                    done    = 1'b1;
                end else if (is_mov) begin
                    reg_wr.en   = 1'b1;
                    reg_wr.data = rd_val;
                    done        = 1'b1;
                end else if (is_alu_r) begin
                    alu_req.alu_op = 1'b1;
                    reg_wr.en      = (opc[5:3] != alu_cmp);
                    reg_wr.idx     = reg_a_idx;
                    done           = 1'b1;
                end else if (is_inr_dcr) begin
                    alu_req.inc_dec = 1'b1;
                    reg_wr.en       = 1'b1;
                    done            = 1'b1;
                end else if (is_jcc && !jump_taken) begin
                    pc_next = pc + 16'd3;       // Skip both address bytes
                    done    = 1'b1;
                end else if (!(is_mvi || is_alu_i || is_jmp || is_jcc || is_out)) begin
                    done = 1'b1;                // NOP and unsupported
                end
            end
            2'd1: begin
                pc_next = pc + 16'd1;
                if (is_mvi) begin
                    reg_wr.en   = 1'b1;
                    reg_wr.data = rd_data;
                    done        = 1'b1;
                end else if (is_alu_i) begin
                    alu_req.alu_op  = 1'b1;
                    alu_req.operand = rd_data;
                    reg_wr.en       = (opc[5:3] != alu_cmp);
                    reg_wr.idx      = reg_a_idx;
                    done            = 1'b1;
                end else if (is_jmp || is_jcc) begin
                    ptr_load = 1'b1;
                end else if (is_out) begin
                    ptr_load = 1'b1;
                    sel_next = 1'b1;            // Put the port on the address bus
                end else begin
                    done = 1'b1;
                end
            end
            default: begin
                done = 1'b1;
                if (is_jmp || is_jcc) begin
                    pc_next = {rd_data, data_ptr};
                end else if (is_out) begin
                    port_wr.we = 1'b1;
                    sel_next   = 1'b0;
                end
            end
        endcase

        step_next = done ? 2'd0 : step + 2'd1;

        if (!ce) begin
            reg_wr.en       = 1'b0;
            alu_req.alu_op  = 1'b0;
            alu_req.inc_dec = 1'b0;
            port_wr.we      = 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            pc       <= 16'h0000;
            step     <= 2'd0;
            addr_sel <= 1'b0;
            opcode   <= 8'h00;
            we_last  <= 1'b0;
        end else if (ce) begin
            pc       <= pc_next;
            step     <= step_next;
            addr_sel <= sel_next;
            we_last  <= port_wr.we;
            if (m0) begin
                opcode <= rd_data;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (ce && ptr_load) begin
            data_ptr <= rd_data;
        end
    end

    // One strobe per OUT even across stalled cycles
    a_we_single : assert property (@(posedge clock) disable iff (!reset_n)
        we_last |-> !port_wr.we)
        else $error("port_wr.we high on two enabled cycles in a row");

    a_step_range : assert property (@(posedge clock) disable iff (!reset_n)
        step <= 2'd2)
        else $error("step counter out of range");

endmodule

/* src/cpu_top.sv */
`timescale 1ns/10ps

module cpu_top
    import cpu_pkg::*;
(
    input  logic        clock,
    input  logic        reset_n,
    input  logic        ce,
    input  logic [ 7:0] rd_data,
    output logic [15:0] address,
    output logic        m0,
    output port_wr_t    port_wr
);

    reg_wr_t    reg_wr;
    alu_req_t   alu_req;
    logic [2:0] rd_sel;
    logic [7:0] rd_val;
    logic [7:0] acc;
    logic [7:0] alu_result;
    logic [7:0] flags;

    seq_ctrl seq_ctrl_i (
        .clock      (clock),
        .reset_n    (reset_n),
        .ce         (ce),
        .rd_data    (rd_data),
        .rd_val     (rd_val),
        .acc        (acc),
        .alu_result (alu_result),
        .flags      (flags),
        .address    (address),
        .m0         (m0),
        .rd_sel     (rd_sel),
        .reg_wr     (reg_wr),
        .alu_req    (alu_req),
        .port_wr    (port_wr)
    );

    reg_file reg_file_i (
        .clock   (clock),
        .reset_n (reset_n),
        .reg_wr  (reg_wr),
        .rd_sel  (rd_sel),
        .rd_val  (rd_val),
        .acc     (acc)
    );

    alu_unit alu_unit_i (
        .clock      (clock),
        .reset_n    (reset_n),
        .ce         (ce),
        .acc        (acc),
        .alu_req    (alu_req),
        .alu_result (alu_result),
        .flags      (flags)
    );

endmodule

/* verif/prog_build.svh */
function automatic logic [7:0] rand_byte();
    return 8'($urandom);
endfunction

task automatic emit_byte(input logic [7:0] b);
    rom[pc_b] = b;
    pc_b      = pc_b + 16'd1;
endtask

task automatic set_flags(input logic [7:0] r, input logic h, input logic c);
    m_flags         = flags_reset;
    m_flags[flag_s] = r[7];
    m_flags[flag_z] = (r == 8'h00);
    m_flags[flag_p] = ~^r;                          // Even parity
    m_flags[flag_h] = h;
    m_flags[flag_c] = c;
endtask

task automatic load_imm(input logic [2:0] r, input logic [7:0] v);
    emit_byte({2'b00, r, 3'b110});
    emit_byte(v);
    m_reg[r] = v;
endtask

task automatic copy_reg(input logic [2:0] d, input logic [2:0] s);
    emit_byte({2'b01, d, s});
    m_reg[d] = m_reg[s];
endtask

task automatic port_out(input logic [7:0] port);
    emit_byte(8'hD3);
    emit_byte(port);
    exp_q.push_back({1'b1, port, m_reg[reg_a_idx]});
endtask

task automatic alu_step(input logic [2:0] op, input logic imm, input logic [2:0] s,
                        input logic [7:0] v);
    logic [7:0] a;
    logic [7:0] b;
    logic [8:0] r;
    logic       cy;
    a  = m_reg[reg_a_idx];
    b  = imm ? v : m_reg[s];
    cy = m_flags[flag_c];
    if (imm) begin
        emit_byte({2'b11, op, 3'b110});
        emit_byte(v);
    end else begin
        emit_byte({2'b10, op, s});
    end
    case (op)
        alu_add: r = {1'b0, a} + {1'b0, b};
        alu_adc: r = {1'b0, a} + {1'b0, b} + {8'h00, cy};
        alu_sbb: r = {1'b0, a} - {1'b0, b} - {8'h00, cy};
        alu_and: r = {1'b0, a & b};
        alu_xor: r = {1'b0, a ^ b};
        alu_or:  r = {1'b0, a | b};
        default: r = {1'b0, a} - {1'b0, b};         // SUB and CMP
    endcase
    if (op == alu_and || op == alu_xor || op == alu_or) begin
        set_flags(r[7:0], (op == alu_and) && (a[4] || b[4]), 1'b0);
    end else begin
        set_flags(r[7:0], a[4] ^ b[4] ^ r[4], r[8]);
    end
    if (op != alu_cmp) begin
        m_reg[reg_a_idx] = r[7:0];
    end
endtask

task automatic bump_reg(input logic [2:0] r, input logic dec);
    emit_byte({2'b00, r, 2'b10, dec});
    m_reg[r] = dec ? m_reg[r] - 8'd1 : m_reg[r] + 8'd1;
    set_flags(m_reg[r], m_flags[flag_h], m_flags[flag_c]);     // H and C kept
endtask

// Jcc over a not-taken path that loads one marker, target loads the other
task automatic cond_jump(input logic [2:0] cc, input logic [7:0] port);
    logic [15:0] target;
    logic [15:0] join_addr;
    logic [ 7:0] cond_flags;
    logic        taken;
    target     = pc_b + 16'd8;
    join_addr  = target + 16'd2;
    cond_flags = {{2{m_flags[flag_s]}}, {2{m_flags[flag_p]}},
                  {2{m_flags[flag_c]}}, {2{m_flags[flag_z]}}};
    taken      = (cond_flags[cc] == cc[0]);         // Odd codes jump on a set flag
    emit_byte({2'b11, cc, 3'b010});
    emit_byte(target[7:0]);
    emit_byte(target[15:8]);
    emit_byte(8'h3E);                               // MVI A, not taken
    emit_byte(8'hA5);
    emit_byte(8'hC3);
    emit_byte(join_addr[7:0]);
    emit_byte(join_addr[15:8]);
    emit_byte(8'h3E);                               // MVI A, taken
    emit_byte(8'h5A);
    m_reg[reg_a_idx] = taken ? 8'h5A : 8'hA5;
    port_out(port);
endtask

task automatic build_program();
    for (int r = 0; r < 8; r++) begin
        if (r != 6) begin
            load_imm(r[2:0], rand_byte());
        end
    end
    for (int r = 0; r < 6; r++) begin
        copy_reg(reg_a_idx, r[2:0]);
        port_out(rand_byte());
    end
    copy_reg(3'd2, 3'd3);                           // E to D to H to A
    copy_reg(3'd4, 3'd2);
    copy_reg(reg_a_idx, 3'd4);
    port_out(rand_byte());
    for (int n = 0; n < 4; n++) begin
        for (int op = 0; op < 8; op++) begin
            load_imm(reg_a_idx, rand_byte());
            load_imm(3'd1, rand_byte());
            alu_step(op[2:0], 1'b0, 3'd1, 8'h00);
            port_out(rand_byte());
            alu_step(op[2:0], 1'b1, 3'd0, rand_byte());
            port_out(rand_byte());
        end
    end
    load_imm(3'd5, 8'hFF);
    bump_reg(3'd5, 1'b0);                           // FF wraps to 00
    copy_reg(reg_a_idx, 3'd5);
    port_out(rand_byte());
    bump_reg(3'd5, 1'b1);                           // And back to FF
    copy_reg(reg_a_idx, 3'd5);
    port_out(rand_byte());
    for (int n = 0; n < 8; n++) begin
        bump_reg(reg_a_idx, 1'($urandom));
        port_out(rand_byte());
    end
    for (int n = 0; n < 3; n++) begin
        for (int cc = 0; cc < 8; cc++) begin
            load_imm(reg_a_idx, rand_byte());
            alu_step(3'($urandom), 1'b1, 3'd0, rand_byte());
            cond_jump(cc[2:0], rand_byte());
        end
    end
    halt_addr = pc_b;
    emit_byte(8'h76);
endtask

/* verif/cpu_tb.sv */
`timescale 1ns/10ps

module cpu_tb
    import cpu_pkg::*;
();

    logic        clock;
    logic        reset_n;
    logic        ce = 1'b0;
    logic [ 7:0] rd_data;
    logic [15:0] address;
    logic        m0;
    port_wr_t    port_wr;

    logic [ 7:0] rom [0:65535];                     // NOP where unwritten
    logic [ 7:0] m_reg [0:7];                       // Expected register contents
    logic [ 7:0] m_flags;
    logic [15:0] pc_b;                              // Assembly pointer
    logic [15:0] halt_addr;
    port_wr_t    exp_q [$];
    port_wr_t    exp_head;
    int          exp_left = 0;
    int          edge_cnt = 0;
    logic        halt_watch = 1'b0;
    int          errors = 0;
    int          timeouts = 0;
    int          cycles;

    `include "prog_build.svh"

    cpu_top cpu_top_i (
        .clock   (clock),
        .reset_n (reset_n),
        .ce      (ce),
        .rd_data (rd_data),
        .address (address),
        .m0      (m0),
        .port_wr (port_wr)
    );

    assign rd_data = rom[address];                  // Combinational program memory

    initial begin
        clock = 1'b0;
        forever begin
            #5 clock = ~clock;
        end
    end

    always @(posedge clock) begin
        ce       <= ($urandom % 5) != 0;            // Stall about one cycle in five
        edge_cnt <= edge_cnt + 1;
    end

    // Pop one expected write per strobe and register the queue head
    always @(posedge clock) begin
        if (reset_n && port_wr.we && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
        end
        exp_left <= exp_q.size();
        exp_head <= (exp_q.size() > 0) ? exp_q[0] : '0;
    end

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------
    a_reset_state : assert property (@(posedge clock)
        (edge_cnt >= 1 && edge_cnt <= 16) |-> (!port_wr.we && address == 16'h0000 && m0))
        else begin
            errors++;
            $display("FAIL reset: port_wr.we %h address %h m0 %h",
                $sampled(port_wr.we), $sampled(address), $sampled(m0));
        end

    a_we_expected : assert property (@(posedge clock) disable iff (!reset_n)
        port_wr.we |-> exp_left != 0)
        else begin
            errors++;
            $display("Port write seen after every expected write was done");
        end

    a_port_write : assert property (@(posedge clock) disable iff (!reset_n)
        (port_wr.we && exp_left != 0) |-> (port_wr.addr == exp_head.addr &&
            port_wr.data == exp_head.data && address == {8'h00, exp_head.addr}))
        else begin
            errors++;
            $display("FAIL port_wr.addr %h exp %h, port_wr.data %h exp %h, address %h exp %h",
                $sampled(port_wr.addr), $sampled(exp_head.addr), $sampled(port_wr.data),
                $sampled(exp_head.data), $sampled(address), {8'h00, $sampled(exp_head.addr)});
        end

    a_stall_quiet : assert property (@(posedge clock) !ce |-> !port_wr.we)
        else begin
            errors++;
            $display("FAIL port_wr.we %h while ce low", $sampled(port_wr.we));
        end

    a_halt_hold : assert property (@(posedge clock)
        halt_watch |-> (address == halt_addr && !port_wr.we))
        else begin
            errors++;
            $display("FAIL halt: address %h exp %h, port_wr.we %h",
                $sampled(address), halt_addr, $sampled(port_wr.we));
        end

    // ------------------------------------------------------------------------
    // Stimulus and report
    // ------------------------------------------------------------------------
    initial begin
        void'($urandom(18805));
        reset_n = 1'b0;
        for (int i = 0; i < 65536; i++) begin
            rom[i] = 8'h00;
        end
        for (int i = 0; i < 8; i++) begin
            m_reg[i] = 8'h00;
        end
        m_flags = flags_reset;
        pc_b    = 16'h0000;
        build_program();

        repeat (16) @(posedge clock);
        reset_n <= 1'b1;

        cycles = 0;
        while (!(exp_left == 0 && m0 && address == halt_addr) && cycles < 20000) begin
            @(negedge clock);
            cycles++;
        end
        if (cycles >= 20000) begin
            timeouts++;
            $display("Timeout: HALT not reached with every port write seen");
        end else begin
            @(posedge clock);
            halt_watch <= 1'b1;                     // Watch the halted core
            repeat (50) @(posedge clock);
            halt_watch <= 1'b0;
        end

        $display("Errors %0d, timeouts %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+verif
src/cpu_pkg.sv
src/alu_unit.sv
src/reg_file.sv
src/seq_ctrl.sv
src/cpu_top.sv
verif/cpu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the CPU testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module cpu_tb -f all.f -o cpu_tb_sim \
    > build.log 2>&1 &&
./obj_dir/cpu_tb_sim > sim.log 2>&1 ||
echo "sim failed" >> sim.log

cat sim.log
grep -q "sim failed" sim.log && exit 1 || exit 0
